//--- Bender.yml
package:
  name: mmu

sources:
  - files:
      - mmu_pkg.sv
      - mmu_csr_apb.sv
      - mmu_tlb_array.sv
      - mmu_va_stage.sv
      - mmu_lookup_stage.sv
      - mmu_resolve_stage.sv
      - mmu_top.sv
  - target: test
    files:
      - mmu_checker.sv
      - tb_mmu.sv

//--- flist.f
mmu_pkg.sv
mmu_csr_apb.sv
mmu_tlb_array.sv
mmu_va_stage.sv
mmu_lookup_stage.sv
mmu_resolve_stage.sv
mmu_top.sv
mmu_checker.sv
tb_mmu.sv

//--- mmu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_checker (
    input logic              aclk,
    input logic              rst,
    input logic              psel,
    input logic              penable,
    input logic              pready,
    input logic              req_ready,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input mmu_pkg::mmu_rsp_t rsp
);
    int fail_count = 0;   // read by the testbench at the end

    // held response must not move under back-pressure
    rsp_hold: assert property (@(posedge aclk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("rsp changed while stalled");
            fail_count++;
        end

    req_ready_after_rst: assert property (@(posedge aclk) $fell(rst) |-> req_ready)
        else begin
            $error("req_ready low after reset");
            fail_count++;
        end

    pready_high: assert property (@(posedge aclk) disable iff (rst) pready)
        else begin
            $error("pready dropped");
            fail_count++;
        end

    penable_needs_psel: assert property (@(posedge aclk) disable iff (rst) penable |-> psel)
        else begin
            $error("penable without psel");
            fail_count++;
        end

endmodule

bind mmu_top mmu_checker chk (
    .aclk      (aclk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

`default_nettype wire

//--- mmu_csr_apb.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_csr_apb (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output mmu_pkg::csr_state_t           csr_state,
    output logic                          tlb_we,
    output logic [mmu_pkg::tlb_idx_w-1:0] tlb_widx,
    output mmu_pkg::tlb_entry_t           tlb_wentry
);
    import mmu_pkg::*;

    logic [31:0] crmd_q;
    logic [31:0] asid_q;
    logic [31:0] dmw0_q;
    logic [31:0] dmw1_q;
    logic [31:0] tlbidx_q;
    logic [31:0] tlbehi_q;
    logic [31:0] tlbelo0_q;
    logic [31:0] tlbelo1_q;
    logic        wr_en;
    logic        mapped;

    function automatic tlb_half_t elo_to_half(input logic [31:0] elo);
        tlb_half_t h;
        h.ppn = elo[27:8];
        h.plv = elo[3:2];
        h.mat = elo[5:4];
        h.d   = elo[1];
        h.v   = elo[0];
        return h;
    endfunction

    assign wr_en   = psel & penable & pwrite;   // access phase write
    assign pready  = 1'b1;                      // zero wait states
    assign pslverr = psel & penable & ~mapped;

    always_comb begin
        mapped = 1'b1;
        prdata = 32'h0;
        case (paddr)
            addr_crmd:    prdata = crmd_q;
            addr_asid:    prdata = asid_q;
            addr_dmw0:    prdata = dmw0_q;
            addr_dmw1:    prdata = dmw1_q;
            addr_tlbidx:  prdata = tlbidx_q;
            addr_tlbehi:  prdata = tlbehi_q;
            addr_tlbelo0: prdata = tlbelo0_q;
            addr_tlbelo1: prdata = tlbelo1_q;
            addr_tlbcmd:  prdata = 32'h0;   // strobe only, reads zero
            default:      mapped = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            crmd_q    <= crmd_rst;
            asid_q    <= 32'h0;
            dmw0_q    <= 32'h0;
            dmw1_q    <= 32'h0;
            tlbidx_q  <= 32'h0;
            tlbehi_q  <= 32'h0;
            tlbelo0_q <= 32'h0;
            tlbelo1_q <= 32'h0;
            tlb_we    <= 1'b0;
        end else begin
            tlb_we <= wr_en & (paddr == addr_tlbcmd) & pwdata[0];   // one cycle commit
            if (wr_en) begin
                case (paddr)
                    addr_crmd:    crmd_q    <= pwdata & crmd_mask;
                    addr_asid:    asid_q    <= pwdata & asid_mask;
                    addr_dmw0:    dmw0_q    <= pwdata & dmw_mask;
                    addr_dmw1:    dmw1_q    <= pwdata & dmw_mask;
                    addr_tlbidx:  tlbidx_q  <= pwdata & tlbidx_mask;
                    addr_tlbehi:  tlbehi_q  <= pwdata & tlbehi_mask;
                    addr_tlbelo0: tlbelo0_q <= pwdata & tlbelo_mask;
                    addr_tlbelo1: tlbelo1_q <= pwdata & tlbelo_mask;
                    default:      ;
                endcase
            end
        end
    end

    assign csr_state.plv  = crmd_q[1:0];
    assign csr_state.da   = crmd_q[3];
    assign csr_state.pg   = crmd_q[4];
    assign csr_state.asid = asid_q[asid_w-1:0];
    assign csr_state.dmw0 = dmw0_q;
    assign csr_state.dmw1 = dmw1_q;

    // staged entry, committed to the index in tlbidx
    assign tlb_widx        = tlbidx_q[tlb_idx_w-1:0];
    assign tlb_wentry.e    = ~tlbidx_q[31];   // ne inverted
    assign tlb_wentry.g    = tlbelo0_q[6] & tlbelo1_q[6];
    assign tlb_wentry.asid = asid_q[asid_w-1:0];
    assign tlb_wentry.vppn = tlbehi_q[31:13];
    assign tlb_wentry.p0   = elo_to_half(tlbelo0_q);
    assign tlb_wentry.p1   = elo_to_half(tlbelo1_q);

endmodule

`default_nettype wire

//--- mmu_lookup_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_lookup_stage (
    input  logic                                           aclk,
    input  logic                                           rst,
    input  logic                                           in_valid,
    input  mmu_pkg::va_stage_t                             in,
    output logic                                           in_allowin,
    input  mmu_pkg::tlb_entry_t [mmu_pkg::tlb_entries-1:0] entries,
    input  mmu_pkg::csr_state_t                            csr_state,
    input  logic                                           out_allowin,
    output logic                                           out_valid,
    output mmu_pkg::lookup_stage_t                         out
);
    import mmu_pkg::*;

    logic                   valid_q;
    logic [tlb_entries-1:0] match;
    logic                   hit;
    tlb_half_t              sel_half;

    assign in_allowin = ~valid_q | out_allowin;

    // compare is masked off for requests already mapped in stage 1
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = ~in.direct & entries[i].e
                     & (entries[i].vppn == in.va[31:13])
                     & (entries[i].g | (entries[i].asid == csr_state.asid));
        end
    end

    assign hit = |match;

    always_comb begin
        sel_half = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_half = in.va[12] ? entries[i].p1 : entries[i].p0;   // lowest index wins
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_allowin) begin
            out.base  <= in;
            out.found <= hit;
            out.half  <= sel_half;
        end
    end

    assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int va_w        = 32;
    localparam int vppn_w      = 19;   // va[31:13]
    localparam int ppn_w       = 20;
    localparam int asid_w      = 10;
    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = 4;

    // apb register offsets
    localparam logic [7:0] addr_crmd    = 8'h00;
    localparam logic [7:0] addr_asid    = 8'h04;
    localparam logic [7:0] addr_dmw0    = 8'h08;
    localparam logic [7:0] addr_dmw1    = 8'h0C;
    localparam logic [7:0] addr_tlbidx  = 8'h10;
    localparam logic [7:0] addr_tlbehi  = 8'h14;
    localparam logic [7:0] addr_tlbelo0 = 8'h18;
    localparam logic [7:0] addr_tlbelo1 = 8'h1C;
    localparam logic [7:0] addr_tlbcmd  = 8'h20;

    // implemented bits of each register
    localparam logic [31:0] crmd_mask   = 32'h0000_001B;   // plv, da, pg
    localparam logic [31:0] asid_mask   = 32'h0000_03FF;
    localparam logic [31:0] dmw_mask    = 32'hEE00_0039;   // vseg, pseg, mat, plv3, plv0
    localparam logic [31:0] tlbidx_mask = 32'h8000_000F;   // ne, index
    localparam logic [31:0] tlbehi_mask = 32'hFFFF_E000;
    localparam logic [31:0] tlbelo_mask = 32'h0FFF_FF7F;

    localparam logic [31:0] crmd_rst = 32'h0000_0008;   // come up in direct mode
    localparam logic [1:0]  da_mat   = 2'd0;            // direct mode memory type

    typedef enum logic [1:0] {
        acc_fetch,
        acc_load,
        acc_store
    } access_e;

    typedef enum logic [2:0] {
        ex_none,
        ex_tlbr,   // no matching entry
        ex_pi,     // page invalid
        ex_ppi,    // privilege
        ex_pme     // store to clean page
    } ex_code_e;

    typedef struct packed {
        logic [1:0]        plv;
        logic              da;
        logic              pg;
        logic [asid_w-1:0] asid;
        logic [31:0]       dmw0;
        logic [31:0]       dmw1;
    } csr_state_t;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_half_t;

    typedef struct packed {
        logic              e;
        logic              g;
        logic [asid_w-1:0] asid;
        logic [vppn_w-1:0] vppn;
        tlb_half_t         p0;   // even page
        tlb_half_t         p1;   // odd page
    } tlb_entry_t;

    typedef struct packed {
        logic [va_w-1:0] va;
        access_e         acc;
    } va_req_t;

    typedef struct packed {
        logic [va_w-1:0] va;
        access_e         acc;
        logic            direct;   // da or window hit
        logic [va_w-1:0] dpa;
        logic [1:0]      dmat;
    } va_stage_t;

    typedef struct packed {
        va_stage_t base;
        logic      found;
        tlb_half_t half;
    } lookup_stage_t;

    typedef struct packed {
        logic [va_w-1:0] pa;
        logic [1:0]      mat;
        ex_code_e        ex;
    } mmu_rsp_t;

endpackage

`default_nettype wire

//--- mmu_resolve_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_resolve_stage (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  mmu_pkg::lookup_stage_t in,
    output logic                   in_allowin,
    input  mmu_pkg::csr_state_t    csr_state,
    input  logic                   rsp_ready,
    output logic                   rsp_valid,
    output mmu_pkg::mmu_rsp_t      rsp
);
    import mmu_pkg::*;

    logic     valid_q;
    mmu_rsp_t next;

    // response reg only reloads once the held one is taken
    assign in_allowin = ~valid_q | rsp_ready;

    always_comb begin
        next     = '0;
        next.ex  = ex_none;
        if (in.base.direct) begin
            next.pa  = in.base.dpa;
            next.mat = in.base.dmat;
        end else if (!in.found) begin
            next.ex = ex_tlbr;
        end else if (!in.half.v) begin
            next.ex = ex_pi;
        end else if (csr_state.plv > in.half.plv) begin
            next.ex = ex_ppi;
        end else if (in.base.acc == acc_store && !in.half.d) begin
            next.ex = ex_pme;
        end else begin
            next.pa  = {in.half.ppn, in.base.va[11:0]};   // 4k page
            next.mat = in.half.mat;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_allowin) begin
            rsp <= next;
        end
    end

    assign rsp_valid = valid_q;

endmodule

`default_nettype wire

//--- mmu_tlb_array.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb_array (
    input  logic                                                aclk,
    input  logic                                                rst,
    input  logic                                                we,
    input  logic [mmu_pkg::tlb_idx_w-1:0]                       widx,
    input  mmu_pkg::tlb_entry_t                                 wentry,
    output mmu_pkg::tlb_entry_t [mmu_pkg::tlb_entries-1:0]      entries
);
    import mmu_pkg::*;

    tlb_entry_t [tlb_entries-1:0] tlb_q;

    // only e is cleared, the rest of an entry is don't-care while e is low
    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < tlb_entries; i++) begin
                tlb_q[i].e <= 1'b0;
            end
        end else if (we) begin
            tlb_q[widx] <= wentry;   // commit from staging regs
        end
    end

    assign entries = tlb_q;   // all entries for the parallel compare

endmodule

`default_nettype wire

//--- mmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_top (
    input  logic               aclk,
    input  logic               rst,
    // apb config port
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    // translation request
    input  logic               req_valid,
    input  mmu_pkg::va_req_t   req,
    output logic               req_ready,
    // translation response
    output logic               rsp_valid,
    output mmu_pkg::mmu_rsp_t  rsp,
    input  logic               rsp_ready
);
    import mmu_pkg::*;

    csr_state_t                   csr_state;
    logic                         tlb_we;
    logic [tlb_idx_w-1:0]         tlb_widx;
    tlb_entry_t                   tlb_wentry;
    tlb_entry_t [tlb_entries-1:0] entries;

    logic          s1_valid;
    va_stage_t     s1_data;
    logic          s2_allowin;
    logic          s2_valid;
    lookup_stage_t s2_data;
    logic          s3_allowin;

    mmu_csr_apb my_csr (
        .aclk       (aclk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .csr_state  (csr_state),
        .tlb_we     (tlb_we),
        .tlb_widx   (tlb_widx),
        .tlb_wentry (tlb_wentry)
    );

    mmu_tlb_array my_tlb (
        .aclk    (aclk),
        .rst     (rst),
        .we      (tlb_we),
        .widx    (tlb_widx),
        .wentry  (tlb_wentry),
        .entries (entries)
    );

    mmu_va_stage my_va (
        .aclk        (aclk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .csr_state   (csr_state),
        .out_allowin (s2_allowin),
        .out_valid   (s1_valid),
        .out         (s1_data)
    );

    mmu_lookup_stage my_lookup (
        .aclk        (aclk),
        .rst         (rst),
        .in_valid    (s1_valid),
        .in          (s1_data),
        .in_allowin  (s2_allowin),
        .entries     (entries),
        .csr_state   (csr_state),
        .out_allowin (s3_allowin),
        .out_valid   (s2_valid),
        .out         (s2_data)
    );

    mmu_resolve_stage my_resolve (
        .aclk       (aclk),
        .rst        (rst),
        .in_valid   (s2_valid),
        .in         (s2_data),
        .in_allowin (s3_allowin),
        .csr_state  (csr_state),
        .rsp_ready  (rsp_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

//--- mmu_va_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mmu_va_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                req_valid,
    input  mmu_pkg::va_req_t    req,
    output logic                req_ready,
    input  mmu_pkg::csr_state_t csr_state,
    input  logic                out_allowin,
    output logic                out_valid,
    output mmu_pkg::va_stage_t  out
);
    import mmu_pkg::*;

    logic      valid_q;
    logic      allowin;
    logic      dmw0_hit;
    logic      dmw1_hit;
    va_stage_t next;

    function automatic logic dmw_hit(
        input logic [31:0] dmw,
        input logic [31:0] va,
        input logic [1:0]  plv
    );
        logic plv_ok;
        plv_ok = ((plv == 2'd0) & dmw[0]) | ((plv == 2'd3) & dmw[3]);
        return (va[31:29] == dmw[31:29]) & plv_ok;
    endfunction

    assign allowin   = ~valid_q | out_allowin;
    assign req_ready = allowin;
    assign dmw0_hit  = dmw_hit(csr_state.dmw0, req.va, csr_state.plv);
    assign dmw1_hit  = dmw_hit(csr_state.dmw1, req.va, csr_state.plv);

    always_comb begin
        next        = '0;
        next.va     = req.va;
        next.acc    = req.acc;
        if (csr_state.da) begin
            next.direct = 1'b1;
            next.dpa    = req.va;
            next.dmat   = da_mat;
        end else if (dmw0_hit) begin   // dmw0 wins over dmw1
            next.direct = 1'b1;
            next.dpa    = {csr_state.dmw0[27:25], req.va[28:0]};
            next.dmat   = csr_state.dmw0[5:4];
        end else if (dmw1_hit) begin
            next.direct = 1'b1;
            next.dpa    = {csr_state.dmw1[27:25], req.va[28:0]};
            next.dmat   = csr_state.dmw1[5:4];
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && allowin) begin
            out <= next;
        end
    end

    assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- tb_mmu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mmu;
    import mmu_pkg::*;

    localparam int clk_period = 4;
    localparam int kind_any   = 0;
    localparam int kind_tlb   = 1;
    localparam int kind_win   = 2;
    localparam int n_requests = 1000;   // sum over all phases below
    localparam int apb_ops    = 200;    // upper bound on apb accesses

    logic        aclk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        req_valid;
    va_req_t     req;
    logic        req_ready;
    logic        rsp_valid;
    mmu_rsp_t    rsp;
    logic        rsp_ready;

    int seed;
    int cycle = 0;

    // reference model of the registers and the tlb
    logic [31:0]       m_reg  [8];   // indexed by offset / 4
    logic              t_e    [tlb_entries];
    logic              t_g    [tlb_entries];
    logic [asid_w-1:0] t_asid [tlb_entries];
    logic [vppn_w-1:0] t_vppn [tlb_entries];
    logic [31:0]       t_elo0 [tlb_entries];
    logic [31:0]       t_elo1 [tlb_entries];

    mmu_rsp_t exp_q   [$];
    int       start_q [$];

    mmu_top dut (
        .aclk      (aclk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    always #(clk_period / 2) aclk = ~aclk;

    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    initial begin
        #((n_requests * 10 + apb_ops * 3 + 20) * clk_period);
        $display("Error: %0t ns timeout, the test did not finish in time", $time);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %0t ns %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] reg_mask(input logic [7:0] addr);
        case (addr)
            addr_crmd:   return 32'h0000_001B;   // plv, da, pg
            addr_asid:   return 32'h0000_03FF;
            addr_dmw0:   return 32'hEE00_0039;   // vseg, pseg, mat, plv3, plv0
            addr_dmw1:   return 32'hEE00_0039;
            addr_tlbidx: return 32'h8000_000F;
            addr_tlbehi: return 32'hFFFF_E000;
            default:     return 32'h0FFF_FF7F;   // tlbelo fields
        endcase
    endfunction

    function automatic logic window_hit(input logic [31:0] dmw, input logic [31:0] va,
                                        input logic [1:0] plv);
        return (va[31:29] == dmw[31:29]) && ((plv == 2'd0 && dmw[0]) || (plv == 2'd3 && dmw[3]));
    endfunction

    function automatic mmu_rsp_t translate(input logic [31:0] va, input access_e acc);
        mmu_rsp_t    r;
        logic [1:0]  plv;
        logic [31:0] elo;
        int          hit;
        r   = '0;
        plv = m_reg[0][1:0];
        hit = -1;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (t_e[i] && t_vppn[i] == va[31:13] && (t_g[i] || t_asid[i] == m_reg[1][9:0])) begin
                hit = i;
            end
        end
        if (m_reg[0][3]) begin
            r.pa = va;   // direct mode, mat 0
        end else if (window_hit(m_reg[2], va, plv)) begin
            r.pa  = {m_reg[2][27:25], va[28:0]};
            r.mat = m_reg[2][5:4];
        end else if (window_hit(m_reg[3], va, plv)) begin
            r.pa  = {m_reg[3][27:25], va[28:0]};
            r.mat = m_reg[3][5:4];
        end else if (hit < 0) begin
            r.ex = ex_tlbr;
        end else begin
            elo = va[12] ? t_elo1[hit] : t_elo0[hit];
            if (!elo[0]) begin
                r.ex = ex_pi;
            end else if (plv > elo[3:2]) begin
                r.ex = ex_ppi;
            end else if (acc == acc_store && !elo[1]) begin
                r.ex = ex_pme;
            end else begin
                r.pa  = {elo[27:8], va[11:0]};
                r.mat = elo[5:4];
            end
        end
        return r;
    endfunction

    task automatic commit_model();
        int idx;
        idx         = m_reg[4][3:0];
        t_e[idx]    = ~m_reg[4][31];
        t_g[idx]    = m_reg[6][6] & m_reg[7][6];
        t_asid[idx] = m_reg[1][9:0];
        t_vppn[idx] = m_reg[5][31:13];
        t_elo0[idx] = m_reg[6];
        t_elo1[idx] = m_reg[7];
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(negedge aclk);
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value("pslverr", {31'b0, err}, 32'h0);
        if (addr == addr_tlbcmd) begin
            if (data[0]) begin
                commit_model();
            end
        end else begin
            m_reg[addr[4:2]] = data & reg_mask(addr);
        end
    endtask

    task automatic read_back(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_value("prdata", rdata, m_reg[addr[4:2]]);
        check_value("pslverr", {31'b0, err}, 32'h0);
    endtask

    task automatic check_unmapped();
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  addr;
        addr = 8'h00;
        while (addr <= addr_tlbcmd && addr[1:0] == 2'b00) begin
            addr = 8'($random(seed));
        end
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_value("pslverr on read", {31'b0, err}, 32'h1);
        apb_access(1'b1, addr, $random(seed), rdata, err);
        check_value("pslverr on write", {31'b0, err}, 32'h1);
    endtask

    function automatic logic [31:0] pick_va(input int kind);
        logic [31:0] va;
        int          idx;
        int          sel;
        va  = $random(seed);
        idx = $random(seed) & 15;
        sel = $random(seed) & 3;
        if (kind == kind_tlb && sel != 0) begin
            va = {t_vppn[idx], va[12:0]};   // hits a committed entry, either half
        end
        if (kind == kind_win) begin
            if (sel == 0) begin
                va[31:29] = m_reg[2][31:29];
            end else if (sel == 1) begin
                va[31:29] = m_reg[3][31:29];
            end else if (sel == 2) begin
                va = {t_vppn[idx], va[12:0]};
            end
        end
        return va;
    endfunction

    task automatic run_requests(input int count, input int kind, input bit gaps);
        int       sent;
        int       received;
        int       start;
        bit       taken;
        mmu_rsp_t exp;
        sent     = 0;
        received = 0;
        taken    = 0;
        while (received < count) begin
            @(negedge aclk);
            if (taken) begin
                req_valid = 1'b0;
                taken     = 0;
            end
            if (!req_valid && sent < count && (!gaps || ($random(seed) & 3) != 0)) begin
                req.va    = pick_va(kind);
                req.acc   = access_e'(($random(seed) & 32'h7fff_ffff) % 3);
                req_valid = 1'b1;
            end
            rsp_ready = gaps ? (($random(seed) & 1) == 1) : 1'b1;
            #1;
            if (req_valid && req_ready) begin
                exp_q.push_back(translate(req.va, req.acc));
                start_q.push_back(cycle);
                sent++;
                taken = 1;
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error: %0t ns a response arrived with no request pending", $time);
                    $display("*** FAILED ***");
                    $fatal(1, "extra response");
                end
                exp   = exp_q.pop_front();
                start = start_q.pop_front();
                check_value("pa", rsp.pa, exp.pa);
                check_value("mat", 32'(rsp.mat), 32'(exp.mat));
                check_value("ex", 32'(rsp.ex), 32'(exp.ex));
                if (!gaps) begin
                    check_value("latency", cycle - start, 3);
                end
                received++;
            end
        end
        @(negedge aclk);
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        check_value("rsp_valid after last response", {31'b0, rsp_valid}, 32'h0);
    endtask

    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        int          round;
        aclk      = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'h00;
        pwdata    = 32'h0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        seed      = 32'h6c50;
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = 32'h0;
        end
        for (int i = 0; i < tlb_entries; i++) begin
            t_e[i]    = 1'b0;
            t_vppn[i] = '0;
        end
        repeat (2) @(negedge aclk);
        rst = 1'b0;

        apb_write(addr_crmd, 32'h8 | ($random(seed) & 3));   // da set
        run_requests(200, kind_any, 1);

        for (int a = 0; a < 8; a++) begin
            apb_write(8'(a * 4), $random(seed));
        end
        for (int a = 0; a < 8; a++) begin
            read_back(8'(a * 4));
        end
        check_unmapped();

        // small asid set so that both g and asid decide a match
        for (int i = 0; i < tlb_entries; i++) begin
            apb_write(addr_asid, $random(seed) & 3);
            apb_write(addr_tlbidx, ((($random(seed) & 7) == 0) ? 32'h8000_0000 : 32'h0) | i);
            apb_write(addr_tlbehi, {15'($random(seed)), 4'(i), 13'h0});   // unique vppn
            apb_write(addr_tlbelo0, $random(seed));
            apb_write(addr_tlbelo1, $random(seed));
            apb_write(addr_tlbcmd, 32'h1);
        end

        apb_write(addr_dmw0, 32'h0);
        apb_write(addr_dmw1, 32'h0);
        for (round = 0; round < 4; round++) begin
            apb_write(addr_crmd, 32'h10 | ($random(seed) & 3));   // pg, random plv
            apb_write(addr_asid, $random(seed) & 3);
            run_requests(100, kind_tlb, 1);
        end
        run_requests(100, kind_tlb, 0);

        for (round = 0; round < 6; round++) begin
            w0 = $random(seed);
            w1 = $random(seed);
            if (round % 3 == 0) begin
                w1[31:29] = w0[31:29];   // overlapping windows
            end
            apb_write(addr_crmd, (round & 1) ? 32'h13 : 32'h10);   // plv 3 or 0
            apb_write(addr_dmw0, w0);
            apb_write(addr_dmw1, w1);
            run_requests(50, kind_win, 1);
        end

        if (dut.chk.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
